// ==== logic/red_pkg.sv ====
////////////////////////////////////////////////////////////
// Reduction offload package
// Widths, operation and opcode encodings, the operand word
// and the structs passed between the pipeline stages
////////////////////////////////////////////////////////////

package red_pkg;

  localparam int unsigned DataWidth = 64;
  localparam int unsigned LaneWidth = 32;
  localparam int unsigned NumLanes  = 2;

  // Minmax mode bit
  localparam logic ModeMax = 1'b0;
  localparam logic ModeMin = 1'b1;

  // Network-side reduction operation, codes 4 to 7 are illegal
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_mul = 3'd1,
    op_max = 3'd2,
    op_min = 3'd3
  } red_op_e;

  // Execution opcode seen by the ALU
  typedef enum logic [1:0] {
    opc_add    = 2'd0,
    opc_mul    = 2'd1,
    opc_minmax = 2'd2
  } exe_opc_e;

  typedef logic signed [LaneWidth-1:0] lane_t;

  // One operand word, scalar or two-lane view
  typedef union packed {
    logic signed [DataWidth-1:0] scalar;
    lane_t       [NumLanes-1:0]  lanes;
  } red_word_u;

  // Offload request from the network side
  typedef struct packed {
    red_op_e         op;
    logic            vec;
    red_word_u [1:0] operands;
  } red_req_t;

  // Execution command with fixed operand slots
  typedef struct packed {
    exe_opc_e        opc;
    logic            mode;
    logic            vec;
    red_word_u [2:0] operands;
  } exe_cmd_t;

  typedef struct packed {
    red_word_u result;
  } red_rsp_t;

endpackage

// ==== logic/red_op_decode.sv ====
////////////////////////////////////////////////////////////
// Reduction operation decoder
// Turns a network reduction op into an execution command
// with the operands placed in their fixed slots
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module red_op_decode
  import red_pkg::*;
(
  input  red_req_t req_i,
  output exe_cmd_t cmd_o
);

  red_word_u opnd_a;
  red_word_u opnd_b;

  assign opnd_a = req_i.operands[0];
  assign opnd_b = req_i.operands[1];

  always_comb begin
    // Unused slots stay zero
    cmd_o      = '0;
    cmd_o.opc  = opc_add;
    cmd_o.mode = ModeMax;
    cmd_o.vec  = req_i.vec;

    case (req_i.op)
      op_add: begin
        // Slot 0 is the unused multiplicand
        cmd_o.opc         = opc_add;
        cmd_o.operands[0] = '0;
        cmd_o.operands[1] = opnd_a;
        cmd_o.operands[2] = opnd_b;
      end
      op_mul: begin
        cmd_o.opc         = opc_mul;
        cmd_o.operands[0] = opnd_a;
        cmd_o.operands[1] = opnd_b;
        cmd_o.operands[2] = '0;
      end
      op_max: begin
        cmd_o.opc         = opc_minmax;
        cmd_o.mode        = ModeMax;
        cmd_o.operands[0] = opnd_a;
        cmd_o.operands[1] = opnd_b;
        cmd_o.operands[2] = '0;
      end
      op_min: begin
        cmd_o.opc         = opc_minmax;
        cmd_o.mode        = ModeMin;
        cmd_o.operands[0] = opnd_a;
        cmd_o.operands[1] = opnd_b;
        cmd_o.operands[2] = '0;
      end
      default: begin
        // Illegal op adds zero to zero
        cmd_o.opc         = opc_add;
        cmd_o.operands[0] = '0;
        cmd_o.operands[1] = '0;
        cmd_o.operands[2] = '0;
      end
    endcase
  end

endmodule

// ==== logic/red_spill_reg.sv ====
////////////////////////////////////////////////////////////
// Spill register
// Two-entry cut on a valid/ready link, registers valid,
// ready and data while keeping one transfer per cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module red_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Primary entry takes every input transfer
  T     prim_data_q;
  logic prim_full_q;
  logic prim_fill;
  logic prim_drain;

  // Overflow entry holds the older item while the output stalls
  T     ovf_data_q;
  logic ovf_full_q;
  logic ovf_fill;
  logic ovf_drain;

  assign prim_fill  = valid_i && ready_o;
  assign prim_drain = prim_full_q && !ovf_full_q;
  assign ovf_fill   = prim_drain && !ready_i;
  assign ovf_drain  = ovf_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prim_full_q <= 1'b0;
      ovf_full_q  <= 1'b0;
    end else begin
      prim_full_q <= prim_fill || (prim_full_q && !prim_drain);
      ovf_full_q  <= ovf_fill || (ovf_full_q && !ovf_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (prim_fill) begin
      prim_data_q <= data_i;
    end
    if (ovf_fill) begin
      ovf_data_q <= prim_data_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Stall upstream only with both entries taken
  assign ready_o = !prim_full_q || !ovf_full_q;
  assign valid_o = prim_full_q || ovf_full_q;

  // Overflow entry is always the older one
  assign data_o  = ovf_full_q ? ovf_data_q : prim_data_q;

endmodule

// ==== logic/red_alu.sv ====
////////////////////////////////////////////////////////////
// Integer reduction ALU
// Registered add, mul, max and min on signed operands,
// one 64-bit scalar or two independent 32-bit lanes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module red_alu
  import red_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     cmd_valid_i,
  output logic     cmd_ready_o,
  input  exe_cmd_t cmd_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output red_rsp_t rsp_o
);

  red_word_u           op_0;
  red_word_u           op_1;
  red_word_u           op_2;
  logic                scalar_lt;
  logic [NumLanes-1:0] lane_lt;
  red_word_u           result_d;
  logic                cmd_fire;
  logic                valid_q;
  red_rsp_t            rsp_q;

  // True when minmax returns slot 0
  function automatic logic take_first(input logic lt, input logic mode);
    return (mode == ModeMin) ? lt : !lt;
  endfunction

  assign op_0 = cmd_i.operands[0];
  assign op_1 = cmd_i.operands[1];
  assign op_2 = cmd_i.operands[2];

  ////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////

  assign scalar_lt = op_0.scalar < op_1.scalar;

  for (genvar i = 0; i < NumLanes; i++) begin : gen_lane_cmp
    assign lane_lt[i] = $signed(op_0.lanes[i]) < $signed(op_1.lanes[i]);
  end

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_d = '0;
    if (cmd_i.vec) begin
      // Lanes wrap on their own, no carry across
      for (int i = 0; i < NumLanes; i++) begin
        case (cmd_i.opc)
          opc_mul: begin
            result_d.lanes[i] = op_0.lanes[i] * op_1.lanes[i];
          end
          opc_minmax: begin
            result_d.lanes[i] = take_first(lane_lt[i], cmd_i.mode) ?
                                op_0.lanes[i] : op_1.lanes[i];
          end
          default: begin
            result_d.lanes[i] = op_1.lanes[i] + op_2.lanes[i];
          end
        endcase
      end
    end else begin
      case (cmd_i.opc)
        opc_mul: begin
          // Low half of the product
          result_d.scalar = op_0.scalar * op_1.scalar;
        end
        opc_minmax: begin
          result_d.scalar = take_first(scalar_lt, cmd_i.mode) ?
                            op_0.scalar : op_1.scalar;
        end
        default: begin
          result_d.scalar = op_1.scalar + op_2.scalar;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  // Accept when empty or while the held result leaves
  assign cmd_ready_o = !valid_q || rsp_ready_i;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (cmd_fire) begin
      valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      rsp_q.result <= result_d;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== logic/red_offload_unit.sv ====
////////////////////////////////////////////////////////////
// Collective reduction offload unit
// Decode, request cut, integer ALU and response cut
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module red_offload_unit
  import red_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  red_req_t req_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output red_rsp_t rsp_o
);

  exe_cmd_t dec_cmd;

  logic     cmd_valid;
  logic     cmd_ready;
  exe_cmd_t cmd;

  logic     alu_rsp_valid;
  logic     alu_rsp_ready;
  red_rsp_t alu_rsp;

  red_op_decode u_red_op_decode (
    .req_i (req_i),
    .cmd_o (dec_cmd)
  );

  // Request cut
  red_spill_reg #(
    .T (exe_cmd_t)
  ) u_req_cut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (dec_cmd),
    .valid_o (cmd_valid),
    .ready_i (cmd_ready),
    .data_o  (cmd)
  );

  red_alu u_red_alu (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .cmd_i       (cmd),
    .rsp_valid_o (alu_rsp_valid),
    .rsp_ready_i (alu_rsp_ready),
    .rsp_o       (alu_rsp)
  );

  // Response cut
  red_spill_reg #(
    .T (red_rsp_t)
  ) u_rsp_cut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (alu_rsp_valid),
    .ready_o (alu_rsp_ready),
    .data_i  (alu_rsp),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i),
    .data_o  (rsp_o)
  );

endmodule

// ==== dv/red_model.svh ====
////////////////////////////////////////////////////////////
// Reduction reference model
// Expected result of one request, taken straight from the
// network-side op, scalar or two wrapping lanes
////////////////////////////////////////////////////////////

`ifndef RED_MODEL_SVH
`define RED_MODEL_SVH

// One 32-bit lane
function automatic logic [LaneWidth-1:0] lane_result(input red_op_e op,
                                                     input logic [LaneWidth-1:0] a,
                                                     input logic [LaneWidth-1:0] b);
  case (op)
    op_add:  return a + b;
    op_mul:  return a * b;
    op_max:  return ($signed(a) >= $signed(b)) ? a : b;
    op_min:  return ($signed(a) <= $signed(b)) ? a : b;
    default: return '0;
  endcase
endfunction

// Full 64-bit scalar
function automatic logic [DataWidth-1:0] scalar_result(input red_op_e op,
                                                       input logic [DataWidth-1:0] a,
                                                       input logic [DataWidth-1:0] b);
  case (op)
    op_add:  return a + b;
    op_mul:  return a * b;
    op_max:  return ($signed(a) >= $signed(b)) ? a : b;
    op_min:  return ($signed(a) <= $signed(b)) ? a : b;
    default: return '0;
  endcase
endfunction

function automatic logic [DataWidth-1:0] model_result(input red_req_t req);
  logic [DataWidth-1:0] a;
  logic [DataWidth-1:0] b;
  logic [DataWidth-1:0] r;
  a = req.operands[0];
  b = req.operands[1];
  r = '0;
  if (req.vec) begin
    for (int i = 0; i < NumLanes; i++) begin
      r[i*LaneWidth +: LaneWidth] = lane_result(req.op, a[i*LaneWidth +: LaneWidth],
                                                b[i*LaneWidth +: LaneWidth]);
    end
  end else begin
    r = scalar_result(req.op, a, b);
  end
  return r;
endfunction

`endif

// ==== dv/red_tb.sv ====
////////////////////////////////////////////////////////////
// Reduction offload unit testbench
// LFSR driven requests, in-order scoreboard against a model,
// latency and back-pressure checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module red_tb
  import red_pkg::*;
();

  localparam logic [31:0] LfsrSeed = 32'h5fc6f755;
  localparam int ScalarReqs  = 200;
  localparam int VectorReqs  = 200;
  localparam int IllegalReqs = 64;
  localparam int LatencyReqs = 64;
  localparam int StallReqs   = 300;
  localparam int DrainCycles = 16;
  localparam int PipeLatency = 3;
  // Gaps and stalls cost at most four cycles per request
  localparam int TestCycles  = 5 + ScalarReqs + VectorReqs + IllegalReqs + LatencyReqs
                             + 4 * StallReqs + 5 * DrainCycles;
  localparam int CycleLimit  = 2 * TestCycles;
  localparam int VecScalar   = 0;
  localparam int VecLanes    = 1;
  localparam int VecMixed    = 2;

  logic     clk_i;
  logic     rst_n_i;
  logic     req_valid_i;
  logic     req_ready_o;
  red_req_t req_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  red_rsp_t rsp_o;

  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;
  int          err_cnt   = 0;
  int          check_cnt = 0;
  int          req_cnt   = 0;
  int          rsp_cnt   = 0;
  logic        req_fire  = 1'b0;
  logic        lat_check_en;
  logic [63:0] exp_q[$];
  int          acc_q[$];

  `include "red_model.svh"

  red_offload_unit u_red_offload_unit (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    while (cycle_cnt < CycleLimit) begin
      @(posedge clk_i);
    end
    $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp_val,
                             input string what);
    check_cnt++;
    if (got !== exp_val) begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp_val);
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[62:0], fb};
    end
    return val;
  endfunction

  function automatic red_req_t make_request(input int vec_sel, input logic illegal_en);
    red_req_t    req;
    logic [63:0] bits;
    bits   = rand_bits(illegal_en ? 3 : 2);
    req.op = red_op_e'(bits[2:0]);
    case (vec_sel)
      VecScalar: req.vec = 1'b0;
      VecLanes:  req.vec = 1'b1;
      default: begin
        bits    = rand_bits(1);
        req.vec = bits[0];
      end
    endcase
    req.operands[0] = rand_bits(64);
    req.operands[1] = rand_bits(64);
    // Equal operands now and then for min and max ties
    bits = rand_bits(3);
    if (bits[2:0] == 3'd0) begin
      req.operands[1] = req.operands[0];
    end
    return req;
  endfunction

  task automatic drive_requests(input int n, input int vec_sel, input logic illegal_en,
                                input logic gap_en, input logic stall_en);
    int          sent;
    logic [63:0] bits;
    sent = 0;
    while (sent < n) begin
      @(posedge clk_i);
      if (req_fire) begin
        sent++;
      end
      if (stall_en) begin
        bits = rand_bits(2);
        rsp_ready_i <= (bits[1:0] != 2'b00);
      end else begin
        rsp_ready_i <= 1'b1;
      end
      if (!req_valid_i || req_fire) begin
        bits = gap_en ? rand_bits(2) : 64'd1;
        if (sent < n && bits[1:0] != 2'b00) begin
          req_valid_i <= 1'b1;
          req_i       <= make_request(vec_sel, illegal_en);
        end else begin
          req_valid_i <= 1'b0;
        end
      end
    end
    rsp_ready_i <= 1'b1;
  endtask

  task automatic run_test(input int num, input string name, input int n, input int vec_sel,
                          input logic illegal_en, input logic gap_en, input logic stall_en);
    int err_base;
    int rsp_base;
    err_base = err_cnt;
    rsp_base = rsp_cnt;
    drive_requests(n, vec_sel, illegal_en, gap_en, stall_en);
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    // Idle cycles to catch duplicate responses
    repeat (4) @(posedge clk_i);
    check_value(64'(rsp_cnt - rsp_base), 64'(n), "response count");
    $display("Test %0d %s: %0d requests, %0d errors", num, name, n, err_cnt - err_base);
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard, sampled mid-cycle for the coming edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    logic [63:0] exp_val;
    int          acc;
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      rsp_cnt++;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Response at %0t ns arrived with no request pending", $time);
      end else begin
        exp_val = exp_q.pop_front();
        acc     = acc_q.pop_front();
        check_value(rsp_o, exp_val, $sformatf("result of response %0d", rsp_cnt));
        if (lat_check_en) begin
          check_value(64'(cycle_cnt - acc), 64'(PipeLatency), "request to response cycles");
        end
      end
    end
    req_fire = rst_n_i && req_valid_i && req_ready_o;
    if (req_fire) begin
      exp_q.push_back(model_result(req_i));
      acc_q.push_back(cycle_cnt);
      req_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    int err_base;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    rsp_ready_i  = 1'b1;
    lat_check_en = 1'b0;
    lfsr_state   = LfsrSeed;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);

    err_base = err_cnt;
    check_value(64'(rsp_valid_o), 64'd0, "rsp_valid_o after reset");
    check_value(64'(req_ready_o), 64'd1, "req_ready_o after reset");
    $display("Test 1 reset state: 2 checks, %0d errors", err_cnt - err_base);

    run_test(2, "scalar random", ScalarReqs, VecScalar, 1'b0, 1'b0, 1'b0);
    run_test(3, "vector random", VectorReqs, VecLanes, 1'b0, 1'b0, 1'b0);
    run_test(4, "illegal ops", IllegalReqs, VecMixed, 1'b1, 1'b0, 1'b0);
    lat_check_en = 1'b1;
    run_test(5, "back-to-back latency", LatencyReqs, VecMixed, 1'b0, 1'b0, 1'b0);
    lat_check_en = 1'b0;
    run_test(6, "gaps and stalls", StallReqs, VecMixed, 1'b1, 1'b1, 1'b1);

    $display("Totals: %0d checks, %0d errors, %0d requests, %0d responses",
             check_cnt, err_cnt, req_cnt, rsp_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+dv
logic/red_pkg.sv
logic/red_op_decode.sv
logic/red_spill_reg.sv
logic/red_alu.sv
logic/red_offload_unit.sv
dv/red_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the reduction offload testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f \
  --top-module red_tb -Mdir obj_dir \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vred_tb 2>&1)"
echo "${sim_out}"
echo "${sim_out}" | grep -qF -- "** PASS **" && exit 0 || exit 1
